//--- periph_config.svh
/*
 * Address map and data widths of the video-clock peripheral bus.
 * Bits 23:16 of the address pick the device. Any code not listed here
 * is unmapped and reads as zero.
 */
`ifndef PERIPH_CONFIG_SVH
`define PERIPH_CONFIG_SVH

// bus widths
`define PERIPH_ADDR_BITS 24
`define PERIPH_DATA_BITS 32
`define PERIPH_HALF_BITS 16

// region field of the address
`define PERIPH_REGION_MSB 23
`define PERIPH_REGION_LSB 16

// device region codes
`define PERIPH_REGION_STATUS 8'h20
`define PERIPH_REGION_DSP    8'h30
`define PERIPH_REGION_PAD    8'h40
`define PERIPH_REGION_COP    8'h50

// copper RAM holds 2048 half-words
`define COP_ADDR_BITS 11

`endif

//--- periph_pkg.sv
/*
 * Shared enums of the peripheral bus.
 * periph_sel_t names the device of the single access in flight.
 */
package periph_pkg;

    // device chosen by the decoder
    typedef enum logic [2:0] {
        SEL_NONE   = 3'd0,
        SEL_STATUS = 3'd1,
        SEL_DSP    = 3'd2,
        SEL_PAD    = 3'd3,
        SEL_COP    = 3'd4
    } periph_sel_t;

    // decoder holds at most one access
    typedef enum logic {
        DEC_IDLE = 1'b0,
        DEC_BUSY = 1'b1
    } dec_state_t;

endpackage

//--- address_decoder.sv
/*
 * Stage 1: accepts one CPU access at a time and issues a one-cycle
 * device strobe. Address, data and strobes are held until the next access.
 * The CPU must keep valid and the payload stable until ready.
 */
`timescale 1ns/1ps
`include "periph_config.svh"

module address_decoder (
    input  logic                          vdp_clk,
    input  logic                          vdp_reset,
    input  logic                          cpu_mem_valid,
    input  logic [`PERIPH_ADDR_BITS-1:0]  cpu_address,
    input  logic [3:0]                    cpu_wstrb,
    input  logic [`PERIPH_DATA_BITS-1:0]  cpu_write_data,
    input  logic                          cpu_mem_ready,
    output periph_pkg::periph_sel_t       sel,
    output logic                          dev_write,
    output logic                          dev_read,
    output logic [`PERIPH_ADDR_BITS-1:0]  dev_addr,
    output logic [`PERIPH_DATA_BITS-1:0]  dev_wdata,
    output logic [3:0]                    dev_wstrb
);
    import periph_pkg::*;

    dec_state_t  state;
    periph_sel_t region_sel;
    logic        accept;

    // region byte to device
    always_comb begin
        case (cpu_address[`PERIPH_REGION_MSB:`PERIPH_REGION_LSB])
            `PERIPH_REGION_STATUS: region_sel = SEL_STATUS;
            `PERIPH_REGION_DSP:    region_sel = SEL_DSP;
            `PERIPH_REGION_PAD:    region_sel = SEL_PAD;
            `PERIPH_REGION_COP:    region_sel = SEL_COP;
            default:               region_sel = SEL_NONE;
        endcase
    end

    // valid is only looked at while idle, so a late drop after ready is harmless
    assign accept = (state == DEC_IDLE) && cpu_mem_valid;

    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            state     <= DEC_IDLE;
            sel       <= SEL_NONE;
            dev_write <= 1'b0;
            dev_read  <= 1'b0;
        end else begin
            dev_write <= 1'b0;
            dev_read  <= 1'b0;
            case (state)
                DEC_IDLE: begin
                    if (accept) begin
                        state     <= DEC_BUSY;
                        sel       <= region_sel;
                        dev_write <= |cpu_wstrb;
                        dev_read  <= ~|cpu_wstrb;
                    end
                end
                default: begin
                    if (cpu_mem_ready) begin
                        state <= DEC_IDLE;
                    end
                end
            endcase
        end
    end

    // payload held from acceptance
    always_ff @(posedge vdp_clk) begin
        if (accept) begin
            dev_addr  <= cpu_address;
            dev_wdata <= cpu_write_data;
            dev_wstrb <= cpu_wstrb;
        end
    end

    // the arbiter only answers an access that was accepted
    assert property (@(posedge vdp_clk) disable iff (vdp_reset)
        (state == DEC_IDLE) |-> !cpu_mem_ready);

endmodule

//--- dsp_multiplier.sv
/*
 * Signed 16x16 multiplier. Operand a sits at address bit 2 = 0 and b
 * at bit 2 = 1. The product is registered on every edge, two edges
 * after an operand write.
 */
`timescale 1ns/1ps
`include "periph_config.svh"

module dsp_multiplier (
    input  logic                          vdp_clk,
    input  logic                          write_en,
    input  logic                          operand_sel,
    input  logic [`PERIPH_HALF_BITS-1:0]  write_data,
    output logic [`PERIPH_DATA_BITS-1:0]  result
);
    logic [`PERIPH_HALF_BITS-1:0] mult_a;
    logic [`PERIPH_HALF_BITS-1:0] mult_b;

    // flat enables keep the operands mappable to DSP input registers
    always_ff @(posedge vdp_clk) begin
        if (write_en && !operand_sel) begin
            mult_a <= write_data;
        end
        if (write_en && operand_sel) begin
            mult_b <= write_data;
        end
    end

    // signed only
    always_ff @(posedge vdp_clk) begin
        result <= $signed(mult_a) * $signed(mult_b);
    end

endmodule

//--- board_io.sv
/*
 * Board device: status LEDs and a gamepad mock fed from three buttons.
 * Buttons are assumed already synchronous to vdp_clk.
 * Pad control bit 0 is latch, bit 1 is the shift clock.
 */
`timescale 1ns/1ps
`include "periph_config.svh"

module board_io (
    input  logic                          vdp_clk,
    input  logic                          vdp_reset,
    input  periph_pkg::periph_sel_t       sel,
    input  logic                          dev_write,
    input  logic [`PERIPH_DATA_BITS-1:0]  dev_wdata,
    input  logic                          btn1,
    input  logic                          btn2,
    input  logic                          btn3,
    output logic                          led_r,
    output logic                          led_b,
    output logic [1:0]                    status_rdata,
    output logic                          pad_rdata
);
    import periph_pkg::*;

    logic [1:0]  status;
    logic [1:0]  pad_ctrl;
    logic        pad_clk_r;
    logic [15:0] pad_shift;
    logic        pad_latch;
    logic        pad_clk;

    assign pad_latch = pad_ctrl[0];
    assign pad_clk   = pad_ctrl[1];

    // led_r on out of reset
    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            status <= 2'b01;
        end else if (dev_write && sel == SEL_STATUS) begin
            status <= dev_wdata[1:0];
        end
    end

    assign led_r        = status[0];
    assign led_b        = status[1];
    assign status_rdata = status;

    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            pad_ctrl  <= 2'b00;
            pad_clk_r <= 1'b0;
        end else begin
            if (dev_write && sel == SEL_PAD) begin
                pad_ctrl <= dev_wdata[1:0];
            end
            pad_clk_r <= pad_clk;
        end
    end

    // btn1, btn3 and btn2 stand in for left, right and B
    always_ff @(posedge vdp_clk) begin
        if (pad_latch) begin
            pad_shift <= {8'b0, btn1, btn3, 5'b0, btn2};
        end
        // rising shift clock wins over latch
        if (pad_clk && !pad_clk_r) begin
            pad_shift <= {1'b0, pad_shift[15:1]};
        end
    end

    assign pad_rdata = pad_shift[0];

endmodule

//--- cop_ram.sv
/*
 * Copper RAM, 2048 half-words, simple dual port.
 * CPU side writes only; video side read data lands one edge after read_en.
 * Contents are undefined until written.
 */
`timescale 1ns/1ps
`include "periph_config.svh"

module cop_ram (
    input  logic                          vdp_clk,
    input  logic                          write_en,
    input  logic [`COP_ADDR_BITS-1:0]     write_address,
    input  logic [`PERIPH_HALF_BITS-1:0]  write_data,
    input  logic                          read_en,
    input  logic [`COP_ADDR_BITS-1:0]     read_address,
    output logic [`PERIPH_HALF_BITS-1:0]  read_data
);
    logic [`PERIPH_HALF_BITS-1:0] mem [0:(1 << `COP_ADDR_BITS)-1];

    always_ff @(posedge vdp_clk) begin
        if (write_en) begin
            mem[write_address] <= write_data;
        end
    end

    // registered read for block RAM
    always_ff @(posedge vdp_clk) begin
        if (read_en) begin
            read_data <= mem[read_address];
        end
    end

endmodule

//--- bus_arbiter.sv
/*
 * Stage 3: read-back mux and ready. The strobe is staged for one edge
 * while the device acts, then ready rises for exactly one cycle.
 * Writes, unmapped and copper accesses return zero.
 */
`timescale 1ns/1ps
`include "periph_config.svh"

module bus_arbiter (
    input  logic                          vdp_clk,
    input  logic                          vdp_reset,
    input  periph_pkg::periph_sel_t       sel,
    input  logic                          dev_write,
    input  logic                          dev_read,
    input  logic [1:0]                    status_rdata,
    input  logic [`PERIPH_DATA_BITS-1:0]  dsp_rdata,
    input  logic                          pad_rdata,
    output logic                          cpu_mem_ready,
    output logic [`PERIPH_DATA_BITS-1:0]  cpu_read_data
);
    import periph_pkg::*;

    periph_sel_t                  sel_q;
    logic                         req_q;
    logic                         rd_q;
    logic [`PERIPH_DATA_BITS-1:0] mux_data;

    // staged while the device does its access
    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            req_q <= 1'b0;
            rd_q  <= 1'b0;
            sel_q <= SEL_NONE;
        end else begin
            req_q <= dev_write || dev_read;
            rd_q  <= dev_read;
            sel_q <= sel;
        end
    end

    always_comb begin
        case (sel_q)
            SEL_STATUS: mux_data = {{(`PERIPH_DATA_BITS-2){1'b0}}, status_rdata};
            SEL_DSP:    mux_data = dsp_rdata;
            SEL_PAD:    mux_data = {{(`PERIPH_DATA_BITS-1){1'b0}}, pad_rdata};
            default:    mux_data = '0;
        endcase
    end

    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            cpu_mem_ready <= 1'b0;
        end else begin
            cpu_mem_ready <= req_q;
        end
    end

    // data only changes with the answer
    always_ff @(posedge vdp_clk) begin
        if (req_q) begin
            cpu_read_data <= rd_q ? mux_data : '0;
        end
    end

    // one outstanding access means one ready per access
    assert property (@(posedge vdp_clk) disable iff (vdp_reset)
        cpu_mem_ready |=> !cpu_mem_ready);

endmodule

//--- periph_top.sv
/*
 * Peripheral bus of the console on the single vdp_clk domain.
 * Every access takes three edges from sampled valid to ready,
 * unmapped regions included. One access in flight at a time.
 */
`timescale 1ns/1ps
`include "periph_config.svh"

module periph_top (
    input  logic                          vdp_clk,
    input  logic                          vdp_reset,
    // CPU memory port
    input  logic                          cpu_mem_valid,
    input  logic [`PERIPH_ADDR_BITS-1:0]  cpu_address,
    input  logic [3:0]                    cpu_wstrb,
    input  logic [`PERIPH_DATA_BITS-1:0]  cpu_write_data,
    output logic                          cpu_mem_ready,
    output logic [`PERIPH_DATA_BITS-1:0]  cpu_read_data,
    // video side copper port
    input  logic                          cop_read_en,
    input  logic [`COP_ADDR_BITS-1:0]     cop_read_address,
    output logic [`PERIPH_HALF_BITS-1:0]  cop_read_data,
    // board pins
    input  logic                          btn1,
    input  logic                          btn2,
    input  logic                          btn3,
    output logic                          led_r,
    output logic                          led_b
);
    import periph_pkg::*;

    periph_sel_t                  sel;
    logic                         dev_write;
    logic                         dev_read;
    logic [`PERIPH_ADDR_BITS-1:0] dev_addr;
    logic [`PERIPH_DATA_BITS-1:0] dev_wdata;
    logic [3:0]                   dev_wstrb;
    logic [1:0]                   status_rdata;
    logic                         pad_rdata;
    logic [`PERIPH_DATA_BITS-1:0] dsp_rdata;
    logic                         dsp_write_en;
    logic                         cop_write_en;

    assign dsp_write_en = dev_write && (sel == SEL_DSP);
    assign cop_write_en = dev_write && (sel == SEL_COP);

    address_decoder decoder_i (
        .vdp_clk        (vdp_clk),
        .vdp_reset      (vdp_reset),
        .cpu_mem_valid  (cpu_mem_valid),
        .cpu_address    (cpu_address),
        .cpu_wstrb      (cpu_wstrb),
        .cpu_write_data (cpu_write_data),
        .cpu_mem_ready  (cpu_mem_ready),
        .sel            (sel),
        .dev_write      (dev_write),
        .dev_read       (dev_read),
        .dev_addr       (dev_addr),
        .dev_wdata      (dev_wdata),
        .dev_wstrb      (dev_wstrb)
    );

    dsp_multiplier dsp_i (
        .vdp_clk     (vdp_clk),
        .write_en    (dsp_write_en),
        .operand_sel (dev_addr[2]),
        .write_data  (dev_wdata[`PERIPH_HALF_BITS-1:0]),
        .result      (dsp_rdata)
    );

    board_io board_i (
        .vdp_clk      (vdp_clk),
        .vdp_reset    (vdp_reset),
        .sel          (sel),
        .dev_write    (dev_write),
        .dev_wdata    (dev_wdata),
        .btn1         (btn1),
        .btn2         (btn2),
        .btn3         (btn3),
        .led_r        (led_r),
        .led_b        (led_b),
        .status_rdata (status_rdata),
        .pad_rdata    (pad_rdata)
    );

    // upper half-word strobe selects the odd entry
    cop_ram cop_i (
        .vdp_clk       (vdp_clk),
        .write_en      (cop_write_en),
        .write_address ({dev_addr[`COP_ADDR_BITS:2], dev_wstrb[2]}),
        .write_data    (dev_wdata[`PERIPH_HALF_BITS-1:0]),
        .read_en       (cop_read_en),
        .read_address  (cop_read_address),
        .read_data     (cop_read_data)
    );

    bus_arbiter arbiter_i (
        .vdp_clk       (vdp_clk),
        .vdp_reset     (vdp_reset),
        .sel           (sel),
        .dev_write     (dev_write),
        .dev_read      (dev_read),
        .status_rdata  (status_rdata),
        .dsp_rdata     (dsp_rdata),
        .pad_rdata     (pad_rdata),
        .cpu_mem_ready (cpu_mem_ready),
        .cpu_read_data (cpu_read_data)
    );

endmodule

//--- tb_periph_top.sv
/*
 * Testbench for the peripheral bus top level.
 * Expected values come from a model of the devices. Copper entries are
 * only read back after they have been written.
 */
`timescale 1ns/1ps
`include "periph_config.svh"

module tb_periph_top;
    logic        vdp_clk;
    logic        vdp_reset;
    logic        cpu_mem_valid;
    logic [23:0] cpu_address;
    logic [3:0]  cpu_wstrb;
    logic [31:0] cpu_write_data;
    logic        cpu_mem_ready;
    logic [31:0] cpu_read_data;
    logic        cop_read_en;
    logic [10:0] cop_read_address;
    logic [15:0] cop_read_data;
    logic        btn1;
    logic        btn2;
    logic        btn3;
    logic        led_r;
    logic        led_b;

    // device model
    logic [1:0]  model_status = 2'b01;
    logic [15:0] model_a;
    logic [15:0] model_b;
    logic [1:0]  model_pad_ctrl = 2'b00;
    logic [15:0] model_pad;
    logic [15:0] model_cop [0:2047];

    logic [15:0] lfsr_state = 16'd53;
    string       name_q[$];
    logic [31:0] got_q[$];
    logic [31:0] exp_q[$];
    int          check_count = 0;
    int          error_count = 0;
    int          test_errors = 0;

    periph_top dut_i (.*);

    initial begin
        vdp_clk = 1'b0;
        forever #5 vdp_clk = ~vdp_clk;
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
        return value;
    endfunction

    // expected CPU read value, copper and unmapped regions answer zero
    function automatic logic [31:0] expected_read(input logic [23:0] addr);
        logic signed [31:0] ext_a;
        logic signed [31:0] ext_b;
        logic [31:0]        value;
        ext_a = {{16{model_a[15]}}, model_a};
        ext_b = {{16{model_b[15]}}, model_b};
        case (addr[`PERIPH_REGION_MSB:`PERIPH_REGION_LSB])
            `PERIPH_REGION_STATUS: value = {30'b0, model_status};
            `PERIPH_REGION_DSP:    value = ext_a * ext_b;
            `PERIPH_REGION_PAD:    value = {31'b0, model_pad[0]};
            default:               value = 32'h0;
        endcase
        return value;
    endfunction

    task automatic model_write(input logic [23:0] addr, input logic [3:0] wstrb,
                               input logic [31:0] data);
        case (addr[`PERIPH_REGION_MSB:`PERIPH_REGION_LSB])
            `PERIPH_REGION_STATUS: model_status = data[1:0];
            `PERIPH_REGION_DSP: begin
                if (addr[2]) model_b = data[15:0];
                else model_a = data[15:0];
            end
            `PERIPH_REGION_PAD: begin
                if (data[0]) model_pad = {8'b0, btn1, btn3, 5'b0, btn2};
                // shift only on a rising shift clock
                if (data[1] && !model_pad_ctrl[1]) model_pad = {1'b0, model_pad[15:1]};
                model_pad_ctrl = data[1:0];
            end
            `PERIPH_REGION_COP: model_cop[{addr[11:2], wstrb[2]}] = data[15:0];
            default: ;
        endcase
    endtask

    task automatic expect_value(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        name_q.push_back(name);
        got_q.push_back(got);
        exp_q.push_back(exp);
    endtask

    // falling edge is clear of the drive and sample points
    always @(negedge vdp_clk) begin
        while (got_q.size() > 0) begin
            check_count++;
            assert (got_q[0] === exp_q[0]) else begin
                $display("error: %s got %h expected %h", name_q[0], got_q[0], exp_q[0]);
                error_count++;
            end
            void'(name_q.pop_front());
            void'(got_q.pop_front());
            void'(exp_q.pop_front());
        end
    end

    // entered and left 1 ns after a rising edge
    task automatic bus_cycle(input logic [23:0] addr, input logic [3:0] wstrb,
                             input logic [31:0] wdata, input bit hold_valid,
                             output logic [31:0] rdata);
        int edges;
        edges = 0;
        cpu_mem_valid  = 1'b1;
        cpu_address    = addr;
        cpu_wstrb      = wstrb;
        cpu_write_data = wdata;
        do begin
            @(posedge vdp_clk);
            #1;
            edges++;
        end while (!cpu_mem_ready && edges < 20);
        if (!cpu_mem_ready) begin
            $display("timeout: no cpu_mem_ready within %0d cycles of valid", edges);
            $display("Finished with errors");
            $finish;
        end else begin
            rdata = cpu_read_data;
            expect_value("ready_latency", edges, 32'd3);
            if (!hold_valid) cpu_mem_valid = 1'b0;
            @(posedge vdp_clk);
            #1;
            expect_value("cpu_mem_ready", {31'b0, cpu_mem_ready}, 32'h0);
            cpu_mem_valid = 1'b0;
        end
    endtask

    task automatic cpu_write(input logic [23:0] addr, input logic [3:0] wstrb,
                             input logic [31:0] data);
        logic [31:0] rdata;
        bus_cycle(addr, wstrb, data, 1'b0, rdata);
        model_write(addr, wstrb, data);
    endtask

    task automatic cpu_read(input logic [23:0] addr);
        logic [31:0] rdata;
        bus_cycle(addr, 4'h0, 32'h0, 1'b0, rdata);
        expect_value("cpu_read_data", rdata, expected_read(addr));
    endtask

    task automatic finish_test(input string name);
        @(negedge vdp_clk);
        #1;
        $display("test %s: %s, %0d errors", name,
                 (error_count == test_errors) ? "passed" : "FAILED", error_count - test_errors);
        test_errors = error_count;
        @(posedge vdp_clk);
        #1;
    endtask

    initial begin
        logic [31:0] data;
        logic [7:0]  region;
        logic [10:0] entries [0:7];
        int          pulses;
        vdp_reset        = 1'b1;
        cpu_mem_valid    = 1'b0;
        cpu_address      = '0;
        cpu_wstrb        = '0;
        cpu_write_data   = '0;
        cop_read_en      = 1'b0;
        cop_read_address = '0;
        btn1             = 1'b0;
        btn2             = 1'b0;
        btn3             = 1'b0;
        repeat (16) @(posedge vdp_clk);
        #1;
        vdp_reset = 1'b0;

        // status LEDs
        expect_value("led_r", {31'b0, led_r}, 32'h1);
        expect_value("led_b", {31'b0, led_b}, 32'h0);
        cpu_read(24'h200000);
        for (int i = 0; i < 4; i++) begin
            cpu_write(24'h200000, 4'hf, random_bits(32));
            expect_value("led_r", {31'b0, led_r}, {31'b0, model_status[0]});
            expect_value("led_b", {31'b0, led_b}, {31'b0, model_status[1]});
            cpu_read(24'h200000);
        end
        finish_test("status");

        // signed products, most negative operands first
        cpu_write(24'h300000, 4'b0011, 32'h8000);
        cpu_write(24'h300004, 4'b0011, 32'h8000);
        cpu_read(24'h300000);
        for (int i = 0; i < 6; i++) begin
            cpu_write(24'h300000, 4'b0011, random_bits(16));
            cpu_write(24'h300004, 4'b0011, random_bits(16));
            cpu_read(24'h300004);
        end
        finish_test("dsp");

        // latch, then clock the buttons out one pulse at a time
        for (int round = 0; round < 3; round++) begin
            data = random_bits(3);
            btn1 = data[0];
            btn2 = data[1];
            btn3 = data[2];
            cpu_write(24'h400000, 4'h1, 32'h1);
            cpu_write(24'h400000, 4'h1, 32'h0);
            cpu_read(24'h400000);
            for (int p = 1; p <= 9; p++) begin
                cpu_write(24'h400000, 4'h1, 32'h2);
                cpu_write(24'h400000, 4'h1, 32'h0);
                cpu_read(24'h400000);
            end
        end
        finish_test("pad");

        // odd entries sit next to the even entry of the same word
        for (int i = 0; i < 8; i++) begin
            if (i % 2 == 1) begin
                entries[i] = entries[i-1] ^ 11'h1;
            end else begin
                data = random_bits(11);
                entries[i] = data[10:0];
            end
            cpu_write({`PERIPH_REGION_COP, 4'h0, entries[i][10:1], 2'b00},
                      entries[i][0] ? 4'b1100 : 4'b0011, random_bits(16));
        end
        cpu_read({`PERIPH_REGION_COP, 16'h0000});
        for (int i = 0; i < 8; i++) begin
            cop_read_en      = 1'b1;
            cop_read_address = entries[i];
            @(posedge vdp_clk);
            #1;
            cop_read_en = 1'b0;
            expect_value("cop_read_data", {16'b0, cop_read_data}, {16'b0, model_cop[entries[i]]});
        end
        finish_test("copper");

        // unmapped regions, then valid held through the ready cycle
        cpu_read(24'h000000);
        data = random_bits(8);
        region = data[7:0];
        if (region inside {`PERIPH_REGION_STATUS, `PERIPH_REGION_DSP,
                           `PERIPH_REGION_PAD, `PERIPH_REGION_COP}) begin
            region = region ^ 8'h01;
        end
        cpu_read({region, 16'h1234});
        cpu_write({region, 16'h0000}, 4'hf, random_bits(32));
        bus_cycle(24'h200000, 4'h0, 32'h0, 1'b1, data);
        expect_value("cpu_read_data", data, expected_read(24'h200000));
        pulses = 0;
        repeat (6) begin
            @(posedge vdp_clk);
            #1;
            if (cpu_mem_ready) pulses++;
        end
        expect_value("ready_count", pulses, 32'd0);
        cpu_write(24'h200000, 4'hf, 32'h2);
        cpu_read(24'h200000);
        cpu_read(24'h600000);
        finish_test("timing");

        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- all.f
+incdir+.
periph_pkg.sv
address_decoder.sv
dsp_multiplier.sv
board_io.sv
cop_ram.sv
bus_arbiter.sv
periph_top.sv
tb_periph_top.sv

//--- Makefile
SIM := obj_dir/Vtb_periph_top

$(SIM): all.f periph_config.svh $(wildcard *.sv)
	verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
		-f all.f --top-module tb_periph_top

run: $(SIM)
	@out=$$(./$(SIM)); echo "$$out"; echo "$$out" | grep -qx "Finished with no errors"

clean:
	rm -rf obj_dir

.PHONY: run clean
